/* tb/dbg_wb_vectors.txt */
// Columns: test, kind (0 write, 1 read, 2 write strobed while busy), size, address
// then write data (upper aligned), expected data_o, expected err_o
01 0 4 00000010 DEADBEEF 00000000 0
02 1 4 00000010 00000000 DEADBEEF 0
03 0 4 00000020 01234567 DEADBEEF 0
04 1 4 00000020 00000000 01234567 0
05 0 1 00000030 A1000000 01234567 0
06 0 1 00000031 B2000000 01234567 0
07 0 1 00000032 C3000000 01234567 0
08 0 1 00000033 D4000000 01234567 0
09 1 4 00000030 00000000 A1B2C3D4 0
0A 1 1 00000030 00000000 000000A1 0
0B 1 1 00000031 00000000 000000B2 0
0C 1 1 00000032 00000000 000000C3 0
0D 1 1 00000033 00000000 000000D4 0
0E 0 1 00000012 55667788 000000D4 0
0F 1 4 00000010 00000000 DEAD55EF 0
10 0 2 00000040 1234ABCD DEAD55EF 0
11 0 2 00000042 56780000 DEAD55EF 0
12 1 4 00000040 00000000 12345678 0
13 1 2 00000040 00000000 00001234 0
14 1 2 00000042 00000000 00005678 0
15 0 2 00000022 FFEE0000 00005678 0
16 1 4 00000020 00000000 0123FFEE 0
17 0 4 00000100 BADBAD00 0123FFEE 1
18 1 4 00000100 00000000 0123FFEE 1
19 1 4 00000010 00000000 DEAD55EF 0
1A 0 1 000001FC 99000000 DEAD55EF 1
1B 1 4 000000FC 00000000 00000000 0
1C 0 4 000000FC CAFEF00D 00000000 0
1D 1 4 00000104 00000000 00000000 1
1E 1 4 000000FC 00000000 CAFEF00D 0
1F 0 4 00000050 11112222 CAFEF00D 0
20 2 4 00000054 33334444 00000000 0
21 1 4 00000054 00000000 00000000 0
22 1 4 00000050 00000000 11112222 0
23 1 0 00000030 00000000 A1B2C3D4 0
24 0 7 00000058 0BADCAFE A1B2C3D4 0
25 1 4 00000058 00000000 0BADCAFE 0

/* dbg_wb_subsystem.f */
common/dbg_wb_pkg.sv
dbg_bridge/dbg_byte_lane.sv
dbg_bridge/dbg_wb_bridge.sv
rtl/dbg_scratch_ram.sv
rtl/dbg_wb_subsystem.sv
tb/dbg_wb_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the debug subsystem testbench with Verilator

set -e

# Paths in the file list and the vector file are relative to the project root
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module dbg_wb_subsystem_tb \
  -Mdir obj_dir \
  -f dbg_wb_subsystem.f

# The simulator exits non-zero on a failed check, the output search decides
sim_out=$(./obj_dir/Vdbg_wb_subsystem_tb 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx 'RESULT: PASS'; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed" >&2
  exit 1
fi

/* tb/dbg_wb_subsystem_tb.sv */
// Debug subsystem testbench: plays vector file accesses through the bridge and checks the results

`timescale 1ns/1ps

module dbg_wb_subsystem_tb;

  localparam int NUM_VEC        = 37;
  localparam int VEC_FIELDS     = 7;
  localparam int RESET_CYCLES   = 16;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 200 * NUM_VEC;
  localparam int RAM_BYTES      = 256;

  logic                  tck_i;
  logic                  wb_clk_i;
  logic                  rst_i;
  dbg_wb_pkg::dbg_cmd_t  cmd_i;
  logic                  strobe_i;
  logic                  rdy_o;
  dbg_wb_pkg::dbg_word_t data_o;
  logic                  err_o;

  // Flat vector table, seven fields per access
  logic [31:0] vec_mem [NUM_VEC*VEC_FIELDS];

  // Byte-wide mirror of the scratch RAM, offset 0 is the MSB lane
  logic [7:0]            model_mem [RAM_BYTES];
  dbg_wb_pkg::dbg_word_t model_last;
  logic [31:0]           rand_state;
  int                    cycle_cnt;

  dbg_wb_subsystem #(
    .BIG_ENDIAN  (1'b1),
    .MEM_WORDS   (64),
    .WAIT_STATES (2)
  ) dbg_wb_subsystem_inst (
    .tck_i    (tck_i),
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .cmd_i    (cmd_i),
    .strobe_i (strobe_i),
    .rdy_o    (rdy_o),
    .data_o   (data_o),
    .err_o    (err_o)
  );

  //////////////////////////////
  // Clocks and watchdog
  //////////////////////////////

  always #20 wb_clk_i = ~wb_clk_i;
  always #50 tck_i = ~tck_i;

  // Limit grows with the number of vectors
  always @(posedge wb_clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run("Timeout: the accesses did not finish within the cycle limit");
    end
  end

  //////////////////////////////
  // Reporting
  //////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic compare_data(input int test_num, input dbg_wb_pkg::dbg_word_t expected,
                              input dbg_wb_pkg::dbg_word_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("Error test %0d: data_o expected %08h actual %08h",
                          test_num, expected, actual));
    end
  endtask

  task automatic compare_err(input int test_num, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("Error test %0d: err_o expected %b actual %b",
                          test_num, expected, actual));
    end
  endtask

  task automatic compare_ready(input int test_num, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("Error test %0d: rdy_o expected %b actual %b",
                          test_num, expected, actual));
    end
  endtask

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Idle gap source
  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic dbg_wb_pkg::dbg_cmd_t build_command(input int idx);
    dbg_wb_pkg::dbg_cmd_t cmd;
    int                   base;
    base       = idx * VEC_FIELDS;
    cmd.addr   = vec_mem[base+3];
    cmd.data   = vec_mem[base+4];
    cmd.rd_wrn = (vec_mem[base+1] == 32'd1);
    cmd.size   = dbg_wb_pkg::dbg_size_e'(vec_mem[base+2][2:0]);
    return cmd;
  endfunction

  // Big endian read, short values low aligned
  function automatic dbg_wb_pkg::dbg_word_t model_read(input dbg_wb_pkg::dbg_cmd_t cmd);
    logic [7:0] a;
    a = cmd.addr[7:0];
    case (cmd.size)
      dbg_wb_pkg::SIZE_BYTE: return {24'h0, model_mem[a]};
      dbg_wb_pkg::SIZE_HALF: begin
        a[0] = 1'b0;
        return {16'h0, model_mem[a], model_mem[a+8'd1]};
      end
      default: begin
        a[1:0] = 2'b00;
        return {model_mem[a], model_mem[a+8'd1], model_mem[a+8'd2], model_mem[a+8'd3]};
      end
    endcase
  endfunction

  // Short write data taken from the top bytes
  task automatic model_write(input dbg_wb_pkg::dbg_cmd_t cmd);
    logic [7:0] a;
    a = cmd.addr[7:0];
    case (cmd.size)
      dbg_wb_pkg::SIZE_BYTE: model_mem[a] = cmd.data[31:24];
      dbg_wb_pkg::SIZE_HALF: begin
        a[0] = 1'b0;
        model_mem[a]      = cmd.data[31:24];
        model_mem[a+8'd1] = cmd.data[23:16];
      end
      default: begin
        a[1:0] = 2'b00;
        for (int b = 0; b < 4; b++) begin
          model_mem[a+8'(b)] = cmd.data[31-8*b -: 8];
        end
      end
    endcase
  endtask

  // Strobe for one tck_i edge, then confirm rdy_o dropped
  task automatic send_command(input dbg_wb_pkg::dbg_cmd_t cmd);
    @(posedge tck_i);
    cmd_i    <= cmd;
    strobe_i <= 1'b1;
    @(posedge tck_i);
    strobe_i <= 1'b0;
    @(negedge tck_i);
    if (rdy_o !== 1'b0) begin
      abort_run("Command was not accepted, rdy_o stayed high");
    end
  endtask

  // Second strobe over two edges while the first access is in flight
  task automatic strobe_while_busy(input dbg_wb_pkg::dbg_cmd_t cmd);
    @(posedge tck_i);
    cmd_i    <= cmd;
    strobe_i <= 1'b1;
    repeat (2) begin
      @(negedge tck_i);
      if (rdy_o !== 1'b0) begin
        abort_run("Access finished before the busy strobe could be tested");
      end
      @(posedge tck_i);
    end
    strobe_i <= 1'b0;
  endtask

  task automatic wait_ready();
    do begin
      @(negedge tck_i);
    end while (rdy_o !== 1'b1);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin : main
    dbg_wb_pkg::dbg_cmd_t  cmd;
    dbg_wb_pkg::dbg_word_t exp_data;
    dbg_wb_pkg::dbg_word_t model_data;
    logic                  exp_err;
    logic                  model_err;
    int                    base;
    int                    idle;
    int                    test_num;
    tck_i      = 1'b0;
    wb_clk_i   = 1'b0;
    rst_i      = 1'b1;
    cmd_i      = '0;
    strobe_i   = 1'b0;
    cycle_cnt  = 0;
    rand_state = 32'd33;
    model_last = '0;
    for (int i = 0; i < RAM_BYTES; i++) begin
      model_mem[i] = 8'h00;
    end
    $readmemh("tb/dbg_wb_vectors.txt", vec_mem);

    repeat (RESET_CYCLES) @(posedge wb_clk_i);
    rst_i <= 1'b0;

    // Idle state after reset, test 0
    @(negedge tck_i);
    compare_ready(0, 1'b1, rdy_o);
    compare_err(0, 1'b0, err_o);
    compare_data(0, '0, data_o);

    for (int i = 0; i < NUM_VEC; i++) begin
      base = i * VEC_FIELDS;
      // Busy-strobe lines are played with the access before them
      if (vec_mem[base+1] == 32'd2) begin
        continue;
      end
      test_num = int'(vec_mem[base]);
      if (test_num != i + 1) begin
        abort_run($sformatf("Vector file out of order at line %0d", i + 1));
      end
      rand_state = next_random(rand_state);
      idle       = int'(rand_state[17:16]);
      repeat (idle) @(posedge tck_i);

      cmd = build_command(i);
      send_command(cmd);
      if (i + 1 < NUM_VEC && vec_mem[base+VEC_FIELDS+1] == 32'd2) begin
        strobe_while_busy(build_command(i + 1));
      end
      wait_ready();

      // Memory model prediction
      model_err = (cmd.addr >= 32'(RAM_BYTES));
      if (cmd.rd_wrn && !model_err) begin
        model_last = model_read(cmd);
      end else if (!cmd.rd_wrn && !model_err) begin
        model_write(cmd);
      end
      model_data = model_last;

      exp_data = vec_mem[base+5];
      exp_err  = vec_mem[base+6][0];
      if (exp_data !== model_data || exp_err !== model_err) begin
        abort_run($sformatf("Vector %0d does not match the memory model", test_num));
      end
      compare_data(test_num, exp_data, data_o);
      compare_err(test_num, exp_err, err_o);
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* rtl/dbg_wb_subsystem.sv */
// Debug subsystem top: debug to Wishbone bridge driving a scratch RAM

`timescale 1ns/1ps

module dbg_wb_subsystem #(
  parameter bit BIG_ENDIAN  = 1'b1,
  parameter int MEM_WORDS   = 64,
  parameter int WAIT_STATES = 2
) (
  input  logic                  tck_i,
  input  logic                  wb_clk_i,
  input  logic                  rst_i,
  input  dbg_wb_pkg::dbg_cmd_t  cmd_i,
  input  logic                  strobe_i,
  output logic                  rdy_o,
  output dbg_wb_pkg::dbg_word_t data_o,
  output logic                  err_o
);

  // Internal Wishbone link
  dbg_wb_pkg::wb_req_t wb_req;
  dbg_wb_pkg::wb_rsp_t wb_rsp;

  // Bus master, crosses from tck_i to wb_clk_i
  dbg_wb_bridge #(
    .BIG_ENDIAN (BIG_ENDIAN)
  ) dbg_wb_bridge_inst (
    .tck_i    (tck_i),
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .cmd_i    (cmd_i),
    .strobe_i (strobe_i),
    .rdy_o    (rdy_o),
    .data_o   (data_o),
    .err_o    (err_o),
    .wb_req_o (wb_req),
    .wb_rsp_i (wb_rsp)
  );

  // Slave memory
  dbg_scratch_ram #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) dbg_scratch_ram_inst (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp)
  );

endmodule

/* rtl/dbg_scratch_ram.sv */
// Wishbone scratch RAM with byte selects, wait states and range error

`timescale 1ns/1ps

module dbg_scratch_ram #(
  parameter int MEM_WORDS   = 64,
  parameter int WAIT_STATES = 2
) (
  input  logic                wb_clk_i,
  input  logic                rst_i,
  input  dbg_wb_pkg::wb_req_t wb_req_i,
  output dbg_wb_pkg::wb_rsp_t wb_rsp_o
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
  localparam dbg_wb_pkg::dbg_addr_t ADDR_END = dbg_wb_pkg::dbg_addr_t'(MEM_WORDS * 4);

  // Storage, cleared at start
  dbg_wb_pkg::dbg_word_t mem [MEM_WORDS] = '{default: '0};

  logic [CNT_W-1:0] wait_cnt;
  logic [IDX_W-1:0] idx;
  logic             req;
  logic             in_range;
  logic             done;

  //////////////////////////////
  // Request decode
  //////////////////////////////

  assign req      = wb_req_i.cyc & wb_req_i.stb;
  assign in_range = (wb_req_i.adr < ADDR_END);
  // Word index, byte offset dropped
  assign idx      = wb_req_i.adr[IDX_W+1:2];

  // Reply in the cycle the count reaches the wait setting
  assign done = req && (wait_cnt == CNT_W'(WAIT_STATES));

  //////////////////////////////
  // Wait state counter
  //////////////////////////////

  // Counts cycles with stb high, restarts after each reply
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      wait_cnt <= '0;
    end else if (!req || done) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  //////////////////////////////
  // Memory write
  //////////////////////////////

  // Byte lanes written only on an acked write
  always_ff @(posedge wb_clk_i) begin
    if (done && in_range && wb_req_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (wb_req_i.sel[b]) begin
          mem[idx][b*8 +: 8] <= wb_req_i.dat[b*8 +: 8];
        end
      end
    end
  end

  //////////////////////////////
  // Response
  //////////////////////////////

  assign wb_rsp_o.ack = done & in_range;
  // Out of range gets err, memory untouched
  assign wb_rsp_o.err = done & ~in_range;
  // Whole word returned, master picks its lanes
  assign wb_rsp_o.dat = in_range ? mem[idx] : '0;

endmodule

/* dbg_bridge/dbg_wb_bridge.sv */
// Debug to Wishbone bridge: tck command latch, toggle handshake and bus FSM

`timescale 1ns/1ps

module dbg_wb_bridge #(
  parameter bit BIG_ENDIAN = 1'b1
) (
  input  logic                  tck_i,
  input  logic                  wb_clk_i,
  input  logic                  rst_i,
  // Debug side, tck_i domain
  input  dbg_wb_pkg::dbg_cmd_t  cmd_i,
  input  logic                  strobe_i,
  output logic                  rdy_o,
  output dbg_wb_pkg::dbg_word_t data_o,
  output logic                  err_o,
  // Wishbone side, wb_clk_i domain
  output dbg_wb_pkg::wb_req_t   wb_req_o,
  input  dbg_wb_pkg::wb_rsp_t   wb_rsp_i
);

  localparam logic STATE_IDLE     = 1'b0;
  localparam logic STATE_TRANSFER = 1'b1;

  // Lane decoder results
  logic [3:0]            sel_dec;
  dbg_wb_pkg::dbg_word_t wdata_dec;
  dbg_wb_pkg::dbg_word_t rdata_dec;

  // Latched access, held steady for the bus cycle
  logic [3:0]            sel_q;
  dbg_wb_pkg::dbg_addr_t addr_q;
  dbg_wb_pkg::dbg_word_t wdata_q;
  logic                  we_q;

  // Handshake toggles, one per direction
  logic start_tgl;
  logic done_tgl;

  // Start toggle seen from wb_clk_i
  logic start_s1;
  logic start_s2;
  logic start_s2_q;
  logic start_evt;

  // Done toggle seen from tck_i
  logic done_s1;
  logic done_s2;
  logic done_s2_q;

  logic accept;
  logic state_q;
  logic state_d;
  logic cyc;
  logic reply;

  // Forward path uses the live command, return path the latched selects
  dbg_byte_lane #(
    .BIG_ENDIAN (BIG_ENDIAN)
  ) dbg_byte_lane_inst (
    .size_i     (cmd_i.size),
    .addr_lo_i  (cmd_i.addr[1:0]),
    .dbg_data_i (cmd_i.data),
    .sel_o      (sel_dec),
    .wb_data_o  (wdata_dec),
    .wb_sel_i   (sel_q),
    .wb_data_i  (wb_rsp_i.dat),
    .dbg_data_o (rdata_dec)
  );

  //////////////////////////////
  // tck_i domain
  //////////////////////////////

  assign accept = strobe_i & rdy_o;

  // Payload capture on acceptance
  always_ff @(posedge tck_i) begin
    if (accept) begin
      sel_q   <= sel_dec;
      addr_q  <= cmd_i.addr;
      wdata_q <= wdata_dec;
      we_q    <= ~cmd_i.rd_wrn;
    end
  end

  // Start toggle, done synchronizer and ready flag
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      start_tgl <= 1'b0;
      done_s1   <= 1'b0;
      done_s2   <= 1'b0;
      done_s2_q <= 1'b0;
      rdy_o     <= 1'b1;
    end else begin
      done_s1   <= done_tgl;
      done_s2   <= done_s1;
      done_s2_q <= done_s2;
      if (accept) begin
        start_tgl <= ~start_tgl;
        rdy_o     <= 1'b0;
      end else if (done_s2 != done_s2_q) begin
        // Completion came back across
        rdy_o <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // wb_clk_i domain
  //////////////////////////////

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      start_s1   <= 1'b0;
      start_s2   <= 1'b0;
      start_s2_q <= 1'b0;
    end else begin
      start_s1   <= start_tgl;
      start_s2   <= start_s1;
      start_s2_q <= start_s2;
    end
  end

  // One-cycle pulse per new command
  assign start_evt = start_s2 ^ start_s2_q;
  assign reply     = wb_rsp_i.ack | wb_rsp_i.err;

  // Bus open on the start pulse and for the whole transfer state
  assign cyc = start_evt | (state_q == STATE_TRANSFER);

  // Zero-wait replies finish while still in idle
  always_comb begin
    state_d = state_q;
    if (cyc) begin
      state_d = reply ? STATE_IDLE : STATE_TRANSFER;
    end
  end

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q  <= STATE_IDLE;
      done_tgl <= 1'b0;
      err_o    <= 1'b0;
      data_o   <= '0;
    end else begin
      state_q <= state_d;
      if (cyc && reply) begin
        done_tgl <= ~done_tgl;
        err_o    <= wb_rsp_i.err;
        // Read data only taken on a good read
        if (wb_rsp_i.ack && !we_q) begin
          data_o <= rdata_dec;
        end
      end
    end
  end

  assign wb_req_o.cyc = cyc;
  assign wb_req_o.stb = cyc;
  assign wb_req_o.we  = we_q;
  assign wb_req_o.sel = sel_q;
  assign wb_req_o.adr = addr_q;
  assign wb_req_o.dat = wdata_q;

endmodule

/* dbg_bridge/dbg_byte_lane.sv */
// Byte lane decoder: size to byte selects and data realignment both ways

`timescale 1ns/1ps

module dbg_byte_lane #(
  parameter bit BIG_ENDIAN = 1'b1
) (
  // Debug to bus direction
  input  dbg_wb_pkg::dbg_size_e size_i,
  input  logic [1:0]            addr_lo_i,
  input  dbg_wb_pkg::dbg_word_t dbg_data_i,
  output logic [3:0]            sel_o,
  output dbg_wb_pkg::dbg_word_t wb_data_o,
  // Bus to debug direction
  input  logic [3:0]            wb_sel_i,
  input  dbg_wb_pkg::dbg_word_t wb_data_i,
  output dbg_wb_pkg::dbg_word_t dbg_data_o
);

  //////////////////////////////
  // Select decode
  //////////////////////////////

  // Big endian: offset 0 is lane 3 (bits 31:24)
  // Little endian: offset 0 is lane 0 (bits 7:0)
  always_comb begin
    case (size_i)
      dbg_wb_pkg::SIZE_BYTE: begin
        if (BIG_ENDIAN) begin
          sel_o = 4'b1000 >> addr_lo_i;
        end else begin
          sel_o = 4'b0001 << addr_lo_i;
        end
      end
      dbg_wb_pkg::SIZE_HALF: begin
        // Halfword lane follows address bit 1 only
        if (BIG_ENDIAN ^ addr_lo_i[1]) begin
          sel_o = 4'b1100;
        end else begin
          sel_o = 4'b0011;
        end
      end
      default: sel_o = 4'b1111;
    endcase
  end

  //////////////////////////////
  // Write data placement
  //////////////////////////////

  // Short debug values are upper aligned
  // Keyed on the selects, so lane order is already resolved
  always_comb begin
    case (sel_o)
      4'b0011: wb_data_o = {16'h0, dbg_data_i[31:16]};
      4'b1100: wb_data_o = {dbg_data_i[31:16], 16'h0};
      4'b0001: wb_data_o = {24'h0, dbg_data_i[31:24]};
      4'b0010: wb_data_o = {16'h0, dbg_data_i[31:24], 8'h0};
      4'b0100: wb_data_o = {8'h0, dbg_data_i[31:24], 16'h0};
      4'b1000: wb_data_o = {dbg_data_i[31:24], 24'h0};
      default: wb_data_o = dbg_data_i;
    endcase
  end

  //////////////////////////////
  // Read data return
  //////////////////////////////

  // Active lanes moved to the low end, rest zeroed
  always_comb begin
    case (wb_sel_i)
      4'b0011: dbg_data_o = {16'h0, wb_data_i[15:0]};
      4'b1100: dbg_data_o = {16'h0, wb_data_i[31:16]};
      4'b0001: dbg_data_o = {24'h0, wb_data_i[7:0]};
      4'b0010: dbg_data_o = {24'h0, wb_data_i[15:8]};
      4'b0100: dbg_data_o = {24'h0, wb_data_i[23:16]};
      4'b1000: dbg_data_o = {24'h0, wb_data_i[31:24]};
      default: dbg_data_o = wb_data_i;
    endcase
  end

endmodule

/* common/dbg_wb_pkg.sv */
// Debug bridge package: access sizes, debug command and Wishbone bus structs

package dbg_wb_pkg;

  //////////////////////////////
  // Basic word types
  //////////////////////////////

  // One data word on either side of the bridge
  typedef logic [31:0] dbg_word_t;

  // Byte address, low two bits pick the lane
  typedef logic [31:0] dbg_addr_t;

  //////////////////////////////
  // Access size codes
  //////////////////////////////

  // Codes as sent by the debug agent
  // Anything not listed is handled as a word access
  typedef enum logic [2:0] {
    SIZE_BYTE = 3'd1,
    SIZE_HALF = 3'd2,
    SIZE_WORD = 3'd4
  } dbg_size_e;

  //////////////////////////////
  // Debug side command
  //////////////////////////////

  // One access from the debug agent
  // Byte and halfword values sit in the upper data bits
  typedef struct packed {
    dbg_addr_t addr;
    dbg_word_t data;
    logic      rd_wrn;
    dbg_size_e size;
  } dbg_cmd_t;

  //////////////////////////////
  // Wishbone classic bus
  //////////////////////////////

  // Master to slave
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    logic [3:0] sel;
    dbg_addr_t  adr;
    dbg_word_t  dat;
  } wb_req_t;

  // Slave to master
  // Ack and err are one-hot, one cycle each
  typedef struct packed {
    logic      ack;
    logic      err;
    dbg_word_t dat;
  } wb_rsp_t;

endpackage
